// File: source/spi_apb_pkg.sv
/* APB bus side definitions */

`default_nettype none

package spi_apb_pkg;

	localparam int APB_ADDR_BITS = 4;
	localparam int APB_DATA_BITS = 32;

	// register map, byte offsets
	localparam logic [APB_ADDR_BITS-1:0] REG_CTRL   = 4'h0;
	localparam logic [APB_ADDR_BITS-1:0] REG_STATUS = 4'h4;
	localparam logic [APB_ADDR_BITS-1:0] REG_TXDATA = 4'h8;
	localparam logic [APB_ADDR_BITS-1:0] REG_RXDATA = 4'hC;

	// STATUS word layout
	localparam int STAT_TX_LSB   = 0;
	localparam int STAT_RX_LSB   = 8;
	localparam int STAT_BUSY_BIT = 16;

	// requester to completer signals
	typedef struct packed {
		logic                     psel;
		logic                     penable;
		logic                     pwrite;
		logic [APB_ADDR_BITS-1:0] paddr;
		logic [APB_DATA_BITS-1:0] pwdata;
	} apb_req_t;

	// completer to requester signals
	typedef struct packed {
		logic [APB_DATA_BITS-1:0] prdata;
		logic                     pready;
		logic                     pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire

// File: source/spi_apb_regs.sv
/* APB register block */

`timescale 1ns/1ps
`default_nettype none

module spi_apb_regs (
	input  logic                              clk_phy_i,
	input  logic                              rst_n_i,
	input  spi_apb_pkg::apb_req_t             apb_req_i,
	input  logic [spi_pkg::SPI_DATA_BITS-1:0] rx_data_i,
	input  spi_pkg::spi_fifo_stat_t           tx_stat_i,
	input  spi_pkg::spi_fifo_stat_t           rx_stat_i,
	input  logic                              busy_i,
	output spi_apb_pkg::apb_rsp_t             apb_rsp_o,
	output logic                              tx_push_o,
	output logic [spi_pkg::SPI_DATA_BITS-1:0] tx_data_o,
	output logic                              rx_pop_o,
	output logic [spi_pkg::SPI_DIV_BITS-1:0]  sclkdiv_o
);

	import spi_pkg::*;
	import spi_apb_pkg::*;

	logic                     access;
	logic                     wr;
	logic                     rd;
	logic                     addr_ok;
	logic                     tx_wr;
	logic                     rx_rd;
	logic [APB_DATA_BITS-1:0] status_word;
	logic [APB_DATA_BITS-1:0] rdata;

	// every action is taken in the access phase
	assign access = apb_req_i.psel && apb_req_i.penable;
	assign wr     = access && apb_req_i.pwrite;
	assign rd     = access && !apb_req_i.pwrite;

	assign addr_ok = (apb_req_i.paddr == REG_CTRL) || (apb_req_i.paddr == REG_STATUS) ||
	                 (apb_req_i.paddr == REG_TXDATA) || (apb_req_i.paddr == REG_RXDATA);

	assign tx_wr = wr && (apb_req_i.paddr == REG_TXDATA);
	assign rx_rd = rd && (apb_req_i.paddr == REG_RXDATA);

	assign tx_push_o = tx_wr && !tx_stat_i.full;
	assign tx_data_o = apb_req_i.pwdata[SPI_DATA_BITS-1:0];
	assign rx_pop_o  = rx_rd && !rx_stat_i.empty;

	always_ff @(posedge clk_phy_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sclkdiv_o <= '0;
		end else if (wr && (apb_req_i.paddr == REG_CTRL)) begin
			sclkdiv_o <= apb_req_i.pwdata[SPI_DIV_BITS-1:0];
		end
	end

	always_comb begin
		status_word = '0;
		status_word[STAT_TX_LSB +: $bits(spi_fifo_stat_t)] = tx_stat_i;
		status_word[STAT_RX_LSB +: $bits(spi_fifo_stat_t)] = rx_stat_i;
		status_word[STAT_BUSY_BIT] = busy_i;
	end

	always_comb begin
		rdata = '0;
		if (rd) begin
			case (apb_req_i.paddr)
				REG_CTRL:   rdata = APB_DATA_BITS'(sclkdiv_o);
				REG_STATUS: rdata = status_word;
				// an empty RX FIFO reads as zero
				REG_RXDATA: rdata = rx_stat_i.empty ? '0 : APB_DATA_BITS'(rx_data_i);
				default:    rdata = '0;
			endcase
		end
	end

	always_comb begin
		apb_rsp_o.prdata  = rdata;
		apb_rsp_o.pready  = 1'b1;
		apb_rsp_o.pslverr = (access && !addr_ok) ||
		                    (tx_wr && tx_stat_i.full) ||
		                    (rx_rd && rx_stat_i.empty);
	end

endmodule

`default_nettype wire

// File: source/spi_apb_top.sv
/* APB SPI master top */

`timescale 1ns/1ps
`default_nettype none

module spi_apb_top (
	input  logic                  clk_phy_i,
	input  logic                  rst_n_i,
	input  spi_apb_pkg::apb_req_t apb_req_i,
	input  logic                  miso_i,
	output spi_apb_pkg::apb_rsp_t apb_rsp_o,
	output logic                  sclk_o,
	output logic                  mosi_o,
	output logic                  cs_o
);

	import spi_pkg::*;

	logic                     tx_push;
	logic [SPI_DATA_BITS-1:0] tx_data;
	logic                     rx_pop;
	logic [SPI_DIV_BITS-1:0]  sclkdiv;
	logic [SPI_DATA_BITS-1:0] rx_data;
	logic                     busy;
	spi_fifo_stat_t           tx_stat;
	spi_fifo_stat_t           rx_stat;

	spi_apb_regs regs (
		.clk_phy_i (clk_phy_i),
		.rst_n_i   (rst_n_i),
		.apb_req_i (apb_req_i),
		.rx_data_i (rx_data),
		.tx_stat_i (tx_stat),
		.rx_stat_i (rx_stat),
		.busy_i    (busy),
		.apb_rsp_o (apb_rsp_o),
		.tx_push_o (tx_push),
		.tx_data_o (tx_data),
		.rx_pop_o  (rx_pop),
		.sclkdiv_o (sclkdiv)
	);

	spi_master master (
		.clk_phy_i (clk_phy_i),
		.rst_n_i   (rst_n_i),
		.tx_push_i (tx_push),
		.tx_data_i (tx_data),
		.rx_pop_i  (rx_pop),
		.sclkdiv_i (sclkdiv),
		.miso_i    (miso_i),
		.rx_data_o (rx_data),
		.tx_stat_o (tx_stat),
		.rx_stat_o (rx_stat),
		.busy_o    (busy),
		.sclk_o    (sclk_o),
		.mosi_o    (mosi_o),
		.cs_o      (cs_o)
	);

endmodule

`default_nettype wire

// File: source/spi_fifo.sv
/* single clock byte FIFO */

`timescale 1ns/1ps
`default_nettype none

module spi_fifo (
	input  logic                              clk_phy_i,
	input  logic                              rst_n_i,
	input  logic                              push_i,
	input  logic [spi_pkg::SPI_DATA_BITS-1:0] data_i,
	input  logic                              pop_i,
	output logic [spi_pkg::SPI_DATA_BITS-1:0] data_o,
	output spi_pkg::spi_fifo_stat_t           stat_o
);

	import spi_pkg::*;

	logic [SPI_DATA_BITS-1:0]  mem [SPI_FIFO_DEPTH];
	logic [SPI_PTR_BITS-1:0]   wr_ptr;
	logic [SPI_PTR_BITS-1:0]   rd_ptr;
	logic [SPI_USAGE_BITS-1:0] usage;
	logic                      full;
	logic                      empty;
	logic                      do_push;
	logic                      do_pop;

	assign full  = (usage == SPI_USAGE_BITS'(SPI_FIFO_DEPTH));
	assign empty = (usage == '0);

	// a push into a full FIFO or a pop from an empty one is dropped
	assign do_push = push_i && !full;
	assign do_pop  = pop_i && !empty;

	always_ff @(posedge clk_phy_i) begin
		if (do_push) begin
			mem[wr_ptr] <= data_i;
		end
	end

	always_ff @(posedge clk_phy_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			usage  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				usage <= usage + 1'b1;
			end else if (do_pop && !do_push) begin
				usage <= usage - 1'b1;
			end
		end
	end

	// head entry is visible before the pop
	assign data_o = mem[rd_ptr];

	assign stat_o.usage = usage;
	assign stat_o.full  = full;
	assign stat_o.empty = empty;

endmodule

`default_nettype wire

// File: source/spi_master.sv
/* SPI master with TX and RX FIFOs */

`timescale 1ns/1ps
`default_nettype none

module spi_master (
	input  logic                              clk_phy_i,
	input  logic                              rst_n_i,
	input  logic                              tx_push_i,
	input  logic [spi_pkg::SPI_DATA_BITS-1:0] tx_data_i,
	input  logic                              rx_pop_i,
	input  logic [spi_pkg::SPI_DIV_BITS-1:0]  sclkdiv_i,
	input  logic                              miso_i,
	output logic [spi_pkg::SPI_DATA_BITS-1:0] rx_data_o,
	output spi_pkg::spi_fifo_stat_t           tx_stat_o,
	output spi_pkg::spi_fifo_stat_t           rx_stat_o,
	output logic                              busy_o,
	output logic                              sclk_o,
	output logic                              mosi_o,
	output logic                              cs_o
);

	import spi_pkg::*;

	logic [SPI_DATA_BITS-1:0] phy_tx_data;
	logic [SPI_DATA_BITS-1:0] phy_rx_data;
	logic                     phy_rdy;
	logic                     phy_rcvd;
	logic                     phy_stb;
	logic                     stb_q;
	logic                     accept;

	spi_fifo fifo_tx (
		.clk_phy_i (clk_phy_i),
		.rst_n_i   (rst_n_i),
		.push_i    (tx_push_i),
		.data_i    (tx_data_i),
		.pop_i     (accept),
		.data_o    (phy_tx_data),
		.stat_o    (tx_stat_o)
	);

	spi_fifo fifo_rx (
		.clk_phy_i (clk_phy_i),
		.rst_n_i   (rst_n_i),
		.push_i    (phy_rcvd),
		.data_i    (phy_rx_data),
		.pop_i     (rx_pop_i),
		.data_o    (rx_data_o),
		.stat_o    (rx_stat_o)
	);

	// a pending RX push counts as full so a new frame always has room for its byte
	assign phy_stb = stb_q && !rx_stat_o.full && !phy_rcvd;
	assign accept  = phy_stb && phy_rdy;

	always_ff @(posedge clk_phy_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			stb_q <= 1'b0;
		end else if (accept) begin
			stb_q <= 1'b0;
		end else if (!tx_stat_o.empty) begin
			stb_q <= 1'b1;
		end
	end

	spi_master_phy phy (
		.clk_phy_i (clk_phy_i),
		.rst_n_i   (rst_n_i),
		.stb_i     (phy_stb),
		.data_i    (phy_tx_data),
		.sclkdiv_i (sclkdiv_i),
		.miso_i    (miso_i),
		.rdy_o     (phy_rdy),
		.rcvd_o    (phy_rcvd),
		.data_o    (phy_rx_data),
		.sclk_o    (sclk_o),
		.mosi_o    (mosi_o),
		.cs_o      (cs_o)
	);

	// busy stays up through the RX push so STATUS never shows idle with a stale usage
	assign busy_o = !tx_stat_o.empty || stb_q || !phy_rdy || phy_rcvd;

endmodule

`default_nettype wire

// File: source/spi_master_phy.sv
/* SPI mode 0 bit engine */

`timescale 1ns/1ps
`default_nettype none

module spi_master_phy (
	input  logic                              clk_phy_i,
	input  logic                              rst_n_i,
	input  logic                              stb_i,
	input  logic [spi_pkg::SPI_DATA_BITS-1:0] data_i,
	input  logic [spi_pkg::SPI_DIV_BITS-1:0]  sclkdiv_i,
	input  logic                              miso_i,
	output logic                              rdy_o,
	output logic                              rcvd_o,
	output logic [spi_pkg::SPI_DATA_BITS-1:0] data_o,
	output logic                              sclk_o,
	output logic                              mosi_o,
	output logic                              cs_o
);

	import spi_pkg::*;

	logic [SPI_DIV_BITS-1:0]  div_q;
	logic [SPI_DIV_BITS-1:0]  div_cnt;
	logic [SPI_HCNT_BITS-1:0] half_cnt;
	logic [SPI_DATA_BITS-1:0] shift_q;
	logic                     miso_q;
	logic                     accept;
	logic                     half_end;
	logic                     last_half;
	logic                     rise_edge;
	logic                     fall_edge;

	assign accept = rdy_o && stb_i;

	// the current sclk half period ends in this cycle
	assign half_end  = !rdy_o && (div_cnt == div_q);
	assign last_half = (half_cnt == SPI_HCNT_BITS'(SPI_FRAME_HALVES));

	// even half periods have sclk low, so their end is a rising edge
	assign rise_edge = half_end && !last_half && !half_cnt[0];
	assign fall_edge = half_end && !last_half && half_cnt[0];

	always_ff @(posedge clk_phy_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rdy_o    <= 1'b1;
			rcvd_o   <= 1'b0;
			cs_o     <= 1'b1;
			sclk_o   <= 1'b0;
			div_q    <= '0;
			div_cnt  <= '0;
			half_cnt <= '0;
		end else begin
			rcvd_o <= 1'b0;
			if (accept) begin
				// divider is frozen for the whole frame
				rdy_o    <= 1'b0;
				cs_o     <= 1'b0;
				div_q    <= sclkdiv_i;
				div_cnt  <= '0;
				half_cnt <= '0;
			end else if (!rdy_o) begin
				if (half_end) begin
					div_cnt  <= '0;
					half_cnt <= half_cnt + 1'b1;
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
				if (rise_edge) begin
					sclk_o <= 1'b1;
				end
				if (fall_edge) begin
					sclk_o <= 1'b0;
				end
				// trailing half period with sclk low closes the frame
				if (half_end && last_half) begin
					cs_o   <= 1'b1;
					rdy_o  <= 1'b1;
					rcvd_o <= 1'b1;
				end
			end
		end
	end

	// shift register starts with the TX byte and ends with the RX byte
	always_ff @(posedge clk_phy_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			shift_q <= '0;
		end else if (accept) begin
			shift_q <= data_i;
		end else if (fall_edge) begin
			shift_q <= {shift_q[SPI_DATA_BITS-2:0], miso_q};
		end
	end

	// miso is sampled on the rising sclk edge and shifted in on the falling one
	always_ff @(posedge clk_phy_i) begin
		if (rise_edge) begin
			miso_q <= miso_i;
		end
	end

	assign mosi_o = shift_q[SPI_DATA_BITS-1];
	assign data_o = shift_q;

endmodule

`default_nettype wire

// File: source/spi_pkg.sv
/* SPI serial side definitions */

`default_nettype none

package spi_pkg;

	// width of one SPI frame
	localparam int SPI_DATA_BITS = 8;

	// width of the sclk half period divider
	localparam int SPI_DIV_BITS = 8;

	// entries held by each of the TX and RX FIFOs
	localparam int SPI_FIFO_DEPTH = 4;

	// a usage count has to reach SPI_FIFO_DEPTH itself
	localparam int SPI_USAGE_BITS = 3;

	// read and write pointer width
	localparam int SPI_PTR_BITS = $clog2(SPI_FIFO_DEPTH);

	// sclk half periods in one frame, two per bit
	localparam int SPI_FRAME_HALVES = 2 * SPI_DATA_BITS;

	// the half period counter also counts the trailing half period before cs rises
	localparam int SPI_HCNT_BITS = $clog2(SPI_FRAME_HALVES + 1);

	// fill state of one FIFO as software sees it in STATUS
	typedef struct packed {
		logic [SPI_USAGE_BITS-1:0] usage;
		logic                      full;
		logic                      empty;
	} spi_fifo_stat_t;

endpackage

`default_nettype wire

// File: sources.f
source/spi_pkg.sv
source/spi_apb_pkg.sv
source/spi_fifo.sv
source/spi_master_phy.sv
source/spi_master.sv
source/spi_apb_regs.sv
source/spi_apb_top.sv
tests/tb_spi_apb_top.sv

// File: tests/spi_vectors.txt
# columns: op offset data expected_prdata expected_pslverr, all in hex
# op W writes, R reads, I waits for idle, F sends a random byte and reads it back
R 4 00000000 00000101 0
W 8 000000a5 00000000 0
I 0 00000000 00000000 0
R 4 00000000 00000401 0
R c 00000000 000000a5 0
R 4 00000000 00000101 0
W 0 00000001 00000000 0
F 0 00000000 00000000 0
W 0 00000007 00000000 0
F 0 00000000 00000000 0
W 0 00000020 00000000 0
F 0 00000000 00000000 0
R 0 00000000 00000020 0
R c 00000000 00000000 1
R f 00000000 00000000 1
W f 00000055 00000000 1
W 0 00000003 00000000 0
W 8 00000011 00000000 0
W 8 00000022 00000000 0
W 8 00000033 00000000 0
W 8 00000044 00000000 0
I 0 00000000 00000000 0
R 4 00000000 00001201 0
W 0 000000ff 00000000 0
W 8 00000055 00000000 0
W 8 00000066 00000000 0
W 8 00000077 00000000 0
W 8 00000088 00000000 0
R 4 00000000 00011212 0
W 8 00000099 00000000 1
R c 00000000 00000011 0
R c 00000000 00000022 0
R c 00000000 00000033 0
R c 00000000 00000044 0
I 0 00000000 00000000 0
R 4 00000000 00001201 0
R c 00000000 00000055 0
R c 00000000 00000066 0
R c 00000000 00000077 0
R c 00000000 00000088 0
R 4 00000000 00000101 0
R 0 00000000 000000ff 0

// File: tests/tb_spi_apb_top.sv
/* APB SPI master testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_spi_apb_top;

	import spi_pkg::*;
	import spi_apb_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int POLL_LIMIT = 20000;

	// one line of the vector file
	typedef struct packed {
		logic [7:0]               op;
		logic [APB_ADDR_BITS-1:0] offset;
		logic [APB_DATA_BITS-1:0] data;
		logic [APB_DATA_BITS-1:0] prdata;
		logic                     pslverr;
	} vector_t;

	logic     clk_phy;
	logic     rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     sclk;
	logic     mosi;
	logic     cs;

	vector_t                 vectors[$];
	integer                  n_vectors;
	integer                  errors;
	integer                  checks;
	integer                  seed;
	integer                  bytes_sent;
	integer                  frames_seen;
	logic [SPI_DIV_BITS-1:0] cur_div;

	// miso is looped back to mosi so every byte returns unchanged
	spi_apb_top dut (
		.clk_phy_i (clk_phy),
		.rst_n_i   (rst_n),
		.apb_req_i (apb_req),
		.miso_i    (mosi),
		.apb_rsp_o (apb_rsp),
		.sclk_o    (sclk),
		.mosi_o    (mosi),
		.cs_o      (cs)
	);

	initial begin
		clk_phy = 1'b0;
		forever #(CLK_PERIOD / 2) clk_phy = ~clk_phy;
	end

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks = checks + 1;
		if (expected !== actual) begin
			errors = errors + 1;
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic apb_transfer(input logic is_write, input logic [APB_ADDR_BITS-1:0] addr,
		input logic [APB_DATA_BITS-1:0] wdata, output logic [APB_DATA_BITS-1:0] rdata,
		output logic err);
		@(negedge clk_phy);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = is_write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clk_phy);
		apb_req.penable = 1'b1;
		// the response is sampled before the edge that ends the access phase
		#(CLK_PERIOD / 4);
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		compare("pready", 1, apb_rsp.pready);
		@(negedge clk_phy);
		apb_req = '0;
		if (is_write && addr == REG_CTRL) begin
			cur_div = wdata[SPI_DIV_BITS-1:0];
		end
		if (is_write && addr == REG_TXDATA && !err) begin
			bytes_sent = bytes_sent + 1;
		end
	endtask

	task automatic wait_idle();
		logic [APB_DATA_BITS-1:0] rdata;
		logic                     err;
		integer                   polls;
		polls = 1;
		apb_transfer(1'b0, REG_STATUS, '0, rdata, err);
		while (rdata[STAT_BUSY_BIT] && polls < POLL_LIMIT) begin
			apb_transfer(1'b0, REG_STATUS, '0, rdata, err);
			polls = polls + 1;
		end
		if (rdata[STAT_BUSY_BIT]) begin
			errors = errors + 1;
			$display("busy did not clear within %0d STATUS reads", polls);
		end
	endtask

	task automatic send_filler();
		logic [31:0]              rnd;
		logic [7:0]               tx_byte;
		logic [APB_DATA_BITS-1:0] rdata;
		logic                     err;
		rnd = $random(seed);
		tx_byte = rnd[7:0];
		apb_transfer(1'b1, REG_TXDATA, {24'h0, tx_byte}, rdata, err);
		compare("pslverr of filler write", 0, err);
		wait_idle();
		apb_transfer(1'b0, REG_RXDATA, '0, rdata, err);
		compare("filler byte read back", {24'h0, tx_byte}, rdata);
		compare("pslverr of filler read", 0, err);
	endtask

	task automatic load_vectors();
		integer                   fd;
		integer                   n;
		logic [7:0]               op;
		logic [APB_ADDR_BITS-1:0] offset;
		logic [APB_DATA_BITS-1:0] data;
		logic [APB_DATA_BITS-1:0] prdata;
		logic                     err;
		logic [8*128-1:0]         rest;
		fd = $fopen("tests/spi_vectors.txt", "r");
		if (fd == 0) begin
			errors = errors + 1;
			$display("could not open the vector file tests/spi_vectors.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, " %c", op);
				if (n == 1 && op == "#") begin
					n = $fgets(rest, fd);
				end else if (n == 1) begin
					n = $fscanf(fd, "%h %h %h %h", offset, data, prdata, err);
					if (n == 4) begin
						vectors.push_back({op, offset, data, prdata, err});
					end else begin
						errors = errors + 1;
						$display("malformed line in the vector file after entry %0d",
						         vectors.size());
					end
				end
			end
			$fclose(fd);
			n_vectors = vectors.size();
		end
	endtask

	// every frame is checked against the divider that was last written
	initial begin : frame_monitor
		integer cycles;
		integer rises;
		logic   sclk_prev;
		cycles = 0;
		rises = 0;
		sclk_prev = 1'b0;
		forever begin
			@(negedge clk_phy);
			if (cs === 1'b0) begin
				cycles = cycles + 1;
				if (sclk && !sclk_prev) begin
					rises = rises + 1;
				end
			end else if (cycles > 0) begin
				frames_seen = frames_seen + 1;
				compare("sclk_o rising edges in a frame", 8, rises);
				if (cycles < 16 * (cur_div + 1)) begin
					errors = errors + 1;
					$display("ERROR at %0t ns: cs_o low for %0d cycles, expected at least %0d",
					         $time, cycles, 16 * (cur_div + 1));
				end
				cycles = 0;
				rises = 0;
			end
			sclk_prev = sclk;
		end
	end

	initial begin : watchdog
		integer limit;
		wait (n_vectors > 0);
		limit = n_vectors * 16 * 256 + 1000;
		repeat (limit) @(posedge clk_phy);
		$display("timeout: the tests did not finish within %0d clock cycles", limit);
		$display("Regression failed");
		$finish;
	end

	initial begin : main
		logic [APB_DATA_BITS-1:0] rdata;
		logic                     err;
		vector_t                  v;
		apb_req = '0;
		rst_n = 1'b0;
		n_vectors = 0;
		errors = 0;
		checks = 0;
		bytes_sent = 0;
		frames_seen = 0;
		cur_div = '0;
		seed = 32'he8c8;
		load_vectors();
		repeat (8) @(negedge clk_phy);
		rst_n = 1'b1;
		@(negedge clk_phy);
		compare("cs_o after reset", 1, cs);
		compare("sclk_o after reset", 0, sclk);
		compare("mosi_o after reset", 0, mosi);
		foreach (vectors[i]) begin
			v = vectors[i];
			case (v.op)
				"W", "R": begin
					apb_transfer(v.op == "W", v.offset, v.data, rdata, err);
					compare($sformatf("prdata of vector %0d", i), v.prdata, rdata);
					compare($sformatf("pslverr of vector %0d", i), v.pslverr, err);
				end
				"I": wait_idle();
				"F": send_filler();
				default: begin
					errors = errors + 1;
					$display("vector %0d has an unknown operation %c", i, v.op);
				end
			endcase
		end
		compare("frames on the SPI bus", bytes_sent, frames_seen);
		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
